// File: Bender.yml
package:
  name: platformer_core

sources:
  - include_dirs:
      - include
    files:
      - rtl/platformer_pkg.sv
      - rtl/key_decoder.sv
      - rtl/coin_tracker.sv
      - rtl/player_physics.sv
      - rtl/frame_status_tx.sv
      - rtl/platformer_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/platformer_tb.sv

// File: dv/platformer_tb.sv
`timescale 1ns/1ns
`include "platformer_consts.svh"

module platformer_tb;
	import platformer_pkg::*;

	// usb hid scan codes
	localparam logic [31:0] KEY_NONE = 32'h0000_0000;
	localparam logic [31:0] KEY_A = 32'h0000_0004;
	localparam logic [31:0] KEY_D = 32'h0000_0007;
	// some 370 frames at 3 cycles each, about 1100 cycles
	localparam int MAX_CYCLES = 4000;

	logic          Clk;
	logic          Reset;
	logic [31:0]   keycode;
	logic          frame_tick;
	logic          credit_return;
	logic          status_valid;
	frame_status_t status;

	// reference model state
	coord_t     m_x;
	coord_t     m_y;
	coord_t     m_scroll;
	logic [3:0] m_grav;
	logic       m_face;
	logic [2:0] m_live;

	// coin sites, tile column and row
	int coin_col [3] = '{`PF_COIN0_COL, `PF_COIN1_COL, `PF_COIN2_COL};
	int coin_row [3] = '{`PF_COIN0_ROW, `PF_COIN1_ROW, `PF_COIN2_ROW};

	int error_count = 0;
	int check_count = 0;
	int tick_count = 0;
	int record_count = 0;
	int cycle_count = 0;

	platformer_core u_platformer_core (
		.Clk           (Clk),
		.Reset         (Reset),
		.keycode       (keycode),
		.frame_tick    (frame_tick),
		.credit_return (credit_return),
		.status_valid  (status_valid),
		.status        (status)
	);

	initial Clk = 1'b0;
	always #5 Clk = ~Clk;

	// --------------------------------------------------
	// level map and reference model
	// --------------------------------------------------
	// ground rows plus the platform and pipe tiles
	function automatic bit solid_tile(input int row, input int col);
		bit s;
		s = 1'b0;
		if (row == 10)
			s = (col >= 14 && col <= 17) || (col >= 25 && col <= 28);
		else if (row == 9)
			s = (col == 15) || (col == 16) || (col >= 26 && col <= 28);
		else if (row == 8)
			s = (col == 19) || (col == 20) || (col == 27) || (col == 28) ||
				(col == 36) || (col == 46) || (col == 56);
		else if (row == 7)
			s = (col == 28) || (col == 36) || (col == 46) || (col == 56);
		// off the map is solid too
		if (row >= `PF_GROUND_ROW || row >= `PF_MAP_ROWS || col >= `PF_MAP_COLS)
			s = 1'b1;
		return s;
	endfunction

	function automatic bit px_clear(input coord_t py, input coord_t px);
		return !solid_tile(int'(py >> `PF_TILE_SHIFT), int'(px >> `PF_TILE_SHIFT));
	endfunction

	// any of the four box corners inside coin i's tile
	function automatic bit coin_hit(input coord_t right, input coord_t bottom, input int i);
		coord_t l;
		coord_t t;
		bit     col_ok;
		bit     row_ok;
		l = right - (`PF_SELF_W - 1);
		t = bottom - (`PF_SELF_H - 1);
		col_ok = (int'(right >> `PF_TILE_SHIFT) == coin_col[i]) ||
			(int'(l >> `PF_TILE_SHIFT) == coin_col[i]);
		row_ok = (int'(bottom >> `PF_TILE_SHIFT) == coin_row[i]) ||
			(int'(t >> `PF_TILE_SHIFT) == coin_row[i]);
		return col_ok && row_ok;
	endfunction

	function automatic int model_score();
		int n;
		n = 0;
		for (int i = 0; i < 3; i++)
			if (!m_live[i])
				n++;
		return n;
	endfunction

	// one accepted frame
	task automatic model_frame(input logic [31:0] key);
		coord_t     right;
		coord_t     left_probe;
		coord_t     top;
		coord_t     probe;
		coord_t     col_px;
		coord_t     step;
		coord_t     x_try;
		coord_t     left_try;
		logic [3:0] g;
		int         mag;
		bit         took;
		right = m_x + m_scroll;
		// floor and wall probes use the pixel just left of the box
		left_probe = right - `PF_SELF_W;
		top = m_y - `PF_SELF_H;

		// coins see the box before the move, first live hit only
		took = 1'b0;
		for (int i = 0; i < 3; i++) begin
			if (m_live[i] && !took && coin_hit(right, m_y, i)) begin
				m_live[i] = 1'b0;
				took = 1'b1;
			end
		end

		// gravity, then snap onto the ground
		probe = m_y + coord_t'(m_grav) + 10'd1;
		if (px_clear(probe, left_probe) && px_clear(probe, right)) begin
			g = (m_grav >= `PF_V_TERMINAL) ? 4'(`PF_V_TERMINAL) : m_grav + 4'd1;
		end else begin
			g = 4'd0;
			for (int k = `PF_V_TERMINAL - 1; k >= 1; k--) begin
				probe = m_y + coord_t'(k);
				if (g == 4'd0 && px_clear(probe, left_probe) && px_clear(probe, right))
					g = 4'(k);
			end
		end

		// largest walk step with top and bottom of the leading edge clear
		mag = 0;
		for (int s = `PF_MAX_VX; s >= 1; s--) begin
			if (key == KEY_D)
				col_px = right + coord_t'(s);
			else
				col_px = left_probe + 10'd1 - coord_t'(s);
			if (mag == 0 && (key == KEY_A || key == KEY_D) &&
				px_clear(m_y, col_px) && px_clear(top, col_px))
				mag = s;
		end
		step = (key == KEY_A) ? 10'd0 - coord_t'(mag) : coord_t'(mag);
		x_try = m_x + step;
		left_try = m_x - `PF_SELF_W + step;
		// past a window edge the view scrolls instead
		if (x_try > `PF_MAX_X_VGA) begin
			m_scroll = m_scroll + step;
			m_x = `PF_MAX_X_VGA;
		end else if (left_try <= `PF_MIN_X_VGA) begin
			m_scroll = m_scroll + step;
			m_x = `PF_MIN_X_VGA + 25;
		end else begin
			m_x = x_try;
		end
		m_y = m_y + coord_t'(g);
		m_grav = g;
		if (key == KEY_A)
			m_face = 1'b1;
		else if (key == KEY_D)
			m_face = 1'b0;
	endtask

	// --------------------------------------------------
	// checks and bus tasks
	// --------------------------------------------------
	task automatic expect_value(input string what, input int got, input int exp);
		check_count++;
		if (got != exp) begin
			error_count++;
			$display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_record();
		expect_value("x", int'(status.x), int'(m_x));
		expect_value("y", int'(status.y), int'(m_y));
		expect_value("scroll", int'(status.scroll), int'(m_scroll));
		expect_value("gravity", int'(status.gravity), int'(m_grav));
		expect_value("face_left", int'(status.face_left), int'(m_face));
		expect_value("score", int'(status.score), model_score());
	endtask

	task automatic apply_reset();
		Reset = 1'b1;
		frame_tick = 1'b0;
		credit_return = 1'b0;
		keycode = KEY_NONE;
		repeat (3) @(posedge Clk);
		#1;
		Reset = 1'b0;
		m_x = `PF_START_X;
		m_y = `PF_START_Y;
		m_scroll = '0;
		m_grav = 4'd0;
		m_face = 1'b0;
		m_live = 3'b111;
		expect_value("status_valid after reset", int'(status_valid), 0);
		check_record();
	endtask

	task automatic return_credit();
		credit_return = 1'b1;
		@(posedge Clk);
		#1;
		credit_return = 1'b0;
	endtask

	// tick with a credit in hand, record expected in the very next cycle
	task automatic do_frame(input logic [31:0] key, input bit give_back);
		int waited;
		keycode = key;
		frame_tick = 1'b1;
		tick_count++;
		@(posedge Clk);
		#1;
		frame_tick = 1'b0;
		waited = 0;
		while (!status_valid && waited < 4) begin
			@(posedge Clk);
			#1;
			waited++;
		end
		if (!status_valid) begin
			error_count++;
			$display("error at %0t: no status record after an accepted frame tick", $time);
		end else begin
			record_count++;
			expect_value("cycles from tick to status_valid", waited, 0);
			model_frame(key);
			check_record();
			@(posedge Clk);
			#1;
			expect_value("status_valid one cycle on", int'(status_valid), 0);
		end
		if (give_back)
			return_credit();
	endtask

	// tick with no credit, nothing may leave and nothing may move
	task automatic drop_frame(input logic [31:0] key);
		keycode = key;
		frame_tick = 1'b1;
		tick_count++;
		@(posedge Clk);
		#1;
		frame_tick = 1'b0;
		repeat (3) begin
			expect_value("status_valid on a dropped tick", int'(status_valid), 0);
			@(posedge Clk);
			#1;
		end
		check_record();
	endtask

	// --------------------------------------------------
	// directed tests
	// --------------------------------------------------
	task automatic fall_to_ground();
		int max_grav;
		int frames;
		bit settled;
		max_grav = 0;
		frames = 0;
		settled = 1'b0;
		while (!settled && frames < 80) begin
			do_frame(KEY_NONE, 1'b1);
			frames++;
			if (int'(status.gravity) > max_grav)
				max_grav = int'(status.gravity);
			settled = (status.gravity == 4'd0);
		end
		expect_value("peak gravity", max_grav, `PF_V_TERMINAL);
		// bottom pixel rests just above the ground row
		expect_value("landed y", int'(status.y), (`PF_GROUND_ROW << `PF_TILE_SHIFT) - 1);
	endtask

	// into the right window edge, then scroll, then the block at column 14
	task automatic walk_right_to_block();
		int ticks0;
		int recs0;
		ticks0 = tick_count;
		recs0 = record_count;
		repeat (58) do_frame(KEY_D, 1'b1);
		expect_value("face_left walking right", int'(status.face_left), 0);
		expect_value("x at right window edge", int'(status.x), `PF_MAX_X_VGA);
		expect_value("records for ticks", record_count - recs0, tick_count - ticks0);
	endtask

	// through the left window edge, then the world wraps round and
	// the player ends up against the block at column 28
	task automatic walk_left_to_wall();
		int     min_x;
		coord_t right_px;
		min_x = 1023;
		repeat (140) begin
			do_frame(KEY_A, 1'b1);
			if (int'(status.x) < min_x)
				min_x = int'(status.x);
		end
		right_px = status.x + status.scroll;
		expect_value("face_left walking left", int'(status.face_left), 1);
		expect_value("x at left clamp", min_x, `PF_MIN_X_VGA + 25);
		// left edge stops on the first clear column past the block
		expect_value("right edge at the block", int'(right_px),
			((28 + 1) << `PF_TILE_SHIFT) + `PF_SELF_W - 1);
	endtask

	// fall from spawn toward coin 0, then walk back the same way
	task automatic sweep_coin_site();
		int prev;
		apply_reset();
		prev = 0;
		for (int f = 0; f < 100; f++) begin
			do_frame((f < 60) ? KEY_D : KEY_A, 1'b1);
			check_count++;
			if (int'(status.score) < prev || int'(status.score) > prev + 1) begin
				error_count++;
				$display("FAIL %0t: score went from %0d to %0d in one frame",
					$time, prev, status.score);
			end
			prev = int'(status.score);
		end
	endtask

	task automatic hold_back_credits();
		do_frame(KEY_A, 1'b0);
		do_frame(KEY_A, 1'b0);
		// both credits out, a right key here must not turn the player
		drop_frame(KEY_D);
		return_credit();
		do_frame(KEY_A, 1'b0);
		// refill the pool
		return_credit();
		return_credit();
	endtask

	task automatic ignore_unknown_keys();
		coord_t      x0;
		coord_t      s0;
		logic [31:0] odd_keys [4];
		odd_keys = '{32'h0000_0016, 32'h0000_0704, 32'hffff_ffff, 32'h0000_0005};
		// once facing left, once facing right
		for (int pass = 0; pass < 2; pass++) begin
			do_frame((pass == 0) ? KEY_A : KEY_D, 1'b1);
			x0 = m_x;
			s0 = m_scroll;
			for (int i = 0; i < 4; i++) begin
				do_frame(odd_keys[i], 1'b1);
				expect_value("x under unknown key", int'(status.x), int'(x0));
				expect_value("scroll under unknown key", int'(status.scroll), int'(s0));
				expect_value("face_left under unknown key", int'(status.face_left),
					(pass == 0) ? 1 : 0);
			end
		end
	endtask

	// --------------------------------------------------
	// run and timeout
	// --------------------------------------------------
	initial begin
		Reset = 1'b1;
		keycode = KEY_NONE;
		frame_tick = 1'b0;
		credit_return = 1'b0;
		apply_reset();
		fall_to_ground();
		walk_right_to_block();
		walk_left_to_wall();
		sweep_coin_site();
		hold_back_credits();
		ignore_unknown_keys();
		$display("checks: %0d  errors: %0d  ticks: %0d  records: %0d",
			check_count, error_count, tick_count, record_count);
		if (error_count == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial begin
		while (cycle_count < MAX_CYCLES) begin
			@(posedge Clk);
			cycle_count++;
		end
		$display("timeout: the run was still going after %0d cycles", MAX_CYCLES);
		$display("checks: %0d  errors: %0d", check_count, error_count);
		$display("** FAIL **");
		$finish;
	end

endmodule

// File: include/platformer_consts.svh
`ifndef PLATFORMER_CONSTS_SVH
`define PLATFORMER_CONSTS_SVH

// --------------------------------------------------
// tile map geometry
// --------------------------------------------------
// tiles are 1 << 5 = 32 pixels square
`define PF_TILE_SHIFT 5
`define PF_MAP_ROWS 15
`define PF_MAP_COLS 60
// first ground row, everything from here down is solid
`define PF_GROUND_ROW 11

// --------------------------------------------------
// player
// --------------------------------------------------
// bounding box in pixels, x/y name the bottom right corner
`define PF_SELF_W 26
`define PF_SELF_H 32
// max fall speed, pixels per frame
`define PF_V_TERMINAL 6
// max walk step, pixels per frame
`define PF_MAX_VX 4
// screen window, scroll takes over past these
`define PF_MAX_X_VGA 384
`define PF_MIN_X_VGA 190
// spawn point after reset
`define PF_START_X 228
`define PF_START_Y 33

// --------------------------------------------------
// coins, tile column and row
// --------------------------------------------------
`define PF_COIN0_COL 14
`define PF_COIN0_ROW 7
`define PF_COIN1_COL 20
`define PF_COIN1_ROW 6
`define PF_COIN2_COL 30
`define PF_COIN2_ROW 8

// status records in flight before a credit must come back
`define PF_STATUS_CREDITS 2

`endif

// File: platformer_core.f
+incdir+include
rtl/platformer_pkg.sv
rtl/key_decoder.sv
rtl/coin_tracker.sv
rtl/player_physics.sv
rtl/frame_status_tx.sv
rtl/platformer_core.sv
dv/platformer_tb.sv

// File: rtl/coin_tracker.sv
`timescale 1ns/1ns
`include "platformer_consts.svh"

module coin_tracker (
	input  logic                        Clk,
	input  logic                        Reset,
	input  logic                        frame_go,
	input  platformer_pkg::player_box_t box,
	output logic [1:0]                  score
);
	import platformer_pkg::*;

	localparam int NUM_COINS = 3;

	// coin sites in tile units, index order is pickup priority
	localparam logic [5:0] COIN_COL [NUM_COINS] = '{
		6'(`PF_COIN0_COL),
		6'(`PF_COIN1_COL),
		6'(`PF_COIN2_COL)
	};
	localparam logic [4:0] COIN_ROW [NUM_COINS] = '{
		5'(`PF_COIN0_ROW),
		5'(`PF_COIN1_ROW),
		5'(`PF_COIN2_ROW)
	};

	coord_t               left_px;
	coord_t               top_px;
	coord_t               col_r_px;
	coord_t               col_l_px;
	coord_t               row_b_px;
	coord_t               row_t_px;
	logic [NUM_COINS-1:0] live;
	logic [NUM_COINS-1:0] touch;
	logic [NUM_COINS-1:0] clear_sel;
	logic                 found;

	// --------------------------------------------------
	// corner tiles of the player box
	// --------------------------------------------------
	always_comb begin
		left_px = box.right - `PF_SELF_W + 1;
		top_px = box.bottom - `PF_SELF_H + 1;
		col_r_px = box.right >> `PF_TILE_SHIFT;
		col_l_px = left_px >> `PF_TILE_SHIFT;
		row_b_px = box.bottom >> `PF_TILE_SHIFT;
		row_t_px = top_px >> `PF_TILE_SHIFT;
	end

	// a corner sits in the coin tile when both its column and row match
	// four corners = either column crossed with either row
	always_comb begin
		for (int i = 0; i < NUM_COINS; i++) begin
			touch[i] = ((col_r_px[5:0] == COIN_COL[i]) || (col_l_px[5:0] == COIN_COL[i])) &&
				((row_b_px[4:0] == COIN_ROW[i]) || (row_t_px[4:0] == COIN_ROW[i]));
		end
	end

	// at most one pickup per frame, lowest index wins
	always_comb begin
		found = 1'b0;
		for (int i = 0; i < NUM_COINS; i++) begin
			clear_sel[i] = live[i] && touch[i] && !found;
			found = found | clear_sel[i];
		end
	end

	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			live <= '1;
		end else if (frame_go) begin
			live <= live & ~clear_sel;
		end
	end

	// score is just the number of coins gone
	always_comb begin
		score = 2'd0;
		for (int i = 0; i < NUM_COINS; i++) begin
			if (!live[i])
				score = score + 2'd1;
		end
	end

endmodule

// File: rtl/frame_status_tx.sv
`timescale 1ns/1ns
`include "platformer_consts.svh"

module frame_status_tx (
	input  logic                          Clk,
	input  logic                          Reset,
	input  logic                          frame_tick,
	input  logic                          credit_return,
	input  platformer_pkg::coord_t        x,
	input  platformer_pkg::coord_t        y,
	input  platformer_pkg::coord_t        scroll,
	input  logic [3:0]                    gravity,
	input  logic                          face_left,
	input  logic [1:0]                    score,
	output logic                          frame_go,
	output logic                          status_valid,
	output platformer_pkg::frame_status_t status
);
	import platformer_pkg::*;

	localparam int CREDIT_W = $clog2(`PF_STATUS_CREDITS + 1);
	localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(`PF_STATUS_CREDITS);

	logic [CREDIT_W-1:0] credits;

	// --------------------------------------------------
	// credit gate
	// --------------------------------------------------
	// a tick with no credit is dropped, nothing moves
	assign frame_go = frame_tick && (credits != '0);

	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			credits <= CREDIT_MAX;
		end else begin
			case ({credit_return, frame_go})
				// return only, never above the starting pool
				2'b10: begin
					if (credits != CREDIT_MAX)
						credits <= credits + 1'b1;
				end
				// spend only
				2'b01: credits <= credits - 1'b1;
				// both or neither, count stays
				default: credits <= credits;
			endcase
		end
	end

	// valid follows the accepted tick by one cycle
	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			status_valid <= 1'b0;
		end else begin
			status_valid <= frame_go;
		end
	end

	// fields are the producers' state registers, which took the frame
	// update at the same edge that raised valid
	// they hold until the next accepted tick, so the record is stable
	// for the whole valid cycle
	assign status = '{
		x: x,
		y: y,
		scroll: scroll,
		gravity: gravity,
		face_left: face_left,
		score: score
	};

endmodule

// File: rtl/key_decoder.sv
`timescale 1ns/1ns

module key_decoder (
	input  logic                      Clk,
	input  logic                      Reset,
	input  logic [31:0]               keycode,
	input  logic                      frame_go,
	output platformer_pkg::move_cmd_e move,
	output logic                      face_left
);
	import platformer_pkg::*;

	// usb hid scan codes
	localparam logic [31:0] KEY_A = 32'h0000_0004;
	localparam logic [31:0] KEY_D = 32'h0000_0007;

	// single key only, combos and other codes mean stand still
	always_comb begin
		case (keycode)
			KEY_A: move = MOVE_LEFT;
			KEY_D: move = MOVE_RIGHT;
			default: move = MOVE_NONE;
		endcase
	end

	// --------------------------------------------------
	// facing direction, sprite mirror flag
	// --------------------------------------------------
	// only moves on accepted frames so a dropped tick leaves it alone
	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			face_left <= 1'b0;
		end else if (frame_go) begin
			case (move)
				MOVE_LEFT: face_left <= 1'b1;
				MOVE_RIGHT: face_left <= 1'b0;
				// no key, keep last facing
				default: face_left <= face_left;
			endcase
		end
	end

endmodule

// File: rtl/platformer_core.sv
`timescale 1ns/1ns

module platformer_core (
	input  logic                          Clk,
	input  logic                          Reset,
	input  logic [31:0]                   keycode,
	input  logic                          frame_tick,
	input  logic                          credit_return,
	output logic                          status_valid,
	output platformer_pkg::frame_status_t status
);
	import platformer_pkg::*;

	move_cmd_e   move;
	logic        face_left;
	logic        frame_go;
	coord_t      x;
	coord_t      y;
	coord_t      scroll;
	logic [3:0]  gravity;
	player_box_t box;
	logic [1:0]  score;

	// --------------------------------------------------
	// input side
	// --------------------------------------------------
	key_decoder u_key_decoder (
		.Clk       (Clk),
		.Reset     (Reset),
		.keycode   (keycode),
		.frame_go  (frame_go),
		.move      (move),
		.face_left (face_left)
	);

	// --------------------------------------------------
	// per frame update
	// --------------------------------------------------
	player_physics u_player_physics (
		.Clk      (Clk),
		.Reset    (Reset),
		.frame_go (frame_go),
		.move     (move),
		.x        (x),
		.y        (y),
		.scroll   (scroll),
		.gravity  (gravity),
		.box      (box)
	);

	// sees the pre-update box, same edge as the move
	coin_tracker u_coin_tracker (
		.Clk      (Clk),
		.Reset    (Reset),
		.frame_go (frame_go),
		.box      (box),
		.score    (score)
	);

	// output side, also owns frame acceptance
	frame_status_tx u_frame_status_tx (
		.Clk           (Clk),
		.Reset         (Reset),
		.frame_tick    (frame_tick),
		.credit_return (credit_return),
		.x             (x),
		.y             (y),
		.scroll        (scroll),
		.gravity       (gravity),
		.face_left     (face_left),
		.score         (score),
		.frame_go      (frame_go),
		.status_valid  (status_valid),
		.status        (status)
	);

endmodule

// File: rtl/platformer_pkg.sv
`include "platformer_consts.svh"

package platformer_pkg;

	// screen or world pixel coordinate
	typedef logic [9:0] coord_t;

	// decoded key command
	typedef enum logic [1:0] {
		MOVE_NONE,
		MOVE_LEFT,
		MOVE_RIGHT
	} move_cmd_e;

	// player position in world space, right edge and bottom row
	typedef struct packed {
		coord_t right;
		coord_t bottom;
	} player_box_t;

	// one record per accepted frame
	typedef struct packed {
		coord_t     x;
		coord_t     y;
		coord_t     scroll;
		logic [3:0] gravity;
		logic       face_left;
		logic [1:0] score;
	} frame_status_t;

	// fixed level layout, rows at or below the ground row are solid
	// platforms and pipes above ground:
	//   row 10: cols 14-17, 25-28
	//   row 9:  cols 15, 16, 26-28
	//   row 8:  cols 19, 20, 27, 28, 36, 46, 56
	//   row 7:  cols 28, 36, 46, 56
	// anything off the map counts as solid too
	function automatic logic tile_is_solid(input logic [4:0] row, input logic [5:0] col);
		logic solid;
		case (row)
			5'd10: solid = (col >= 6'd14 && col <= 6'd17) || (col >= 6'd25 && col <= 6'd28);
			5'd9: solid = (col == 6'd15) || (col == 6'd16) || (col >= 6'd26 && col <= 6'd28);
			5'd8: solid = (col == 6'd19) || (col == 6'd20) || (col == 6'd27) ||
				(col == 6'd28) || (col == 6'd36) || (col == 6'd46) || (col == 6'd56);
			5'd7: solid = (col == 6'd28) || (col == 6'd36) || (col == 6'd46) || (col == 6'd56);
			default: solid = 1'b0;
		endcase
		if (row >= `PF_GROUND_ROW || row >= `PF_MAP_ROWS || col >= `PF_MAP_COLS)
			solid = 1'b1;
		return solid;
	endfunction

endpackage

// File: rtl/player_physics.sv
`timescale 1ns/1ns
`include "platformer_consts.svh"

module player_physics (
	input  logic                        Clk,
	input  logic                        Reset,
	input  logic                        frame_go,
	input  platformer_pkg::move_cmd_e   move,
	output platformer_pkg::coord_t      x,
	output platformer_pkg::coord_t      y,
	output platformer_pkg::coord_t      scroll,
	output logic [3:0]                  gravity,
	output platformer_pkg::player_box_t box
);
	import platformer_pkg::*;

	// all four tiles under two pixel rows by two pixel columns are clear
	function automatic logic corners_clear(
		input coord_t row_a,
		input coord_t row_b,
		input coord_t col_a,
		input coord_t col_b
	);
		coord_t ra;
		coord_t rb;
		coord_t ca;
		coord_t cb;
		ra = row_a >> `PF_TILE_SHIFT;
		rb = row_b >> `PF_TILE_SHIFT;
		ca = col_a >> `PF_TILE_SHIFT;
		cb = col_b >> `PF_TILE_SHIFT;
		return !tile_is_solid(ra[4:0], ca[5:0]) && !tile_is_solid(ra[4:0], cb[5:0]) &&
			!tile_is_solid(rb[4:0], ca[5:0]) && !tile_is_solid(rb[4:0], cb[5:0]);
	endfunction

	coord_t     world_right;
	coord_t     world_left;
	coord_t     top_px;
	coord_t     fall_probe;
	logic       in_air;
	logic [3:0] gravity_next;
	coord_t     y_next;
	logic [2:0] step_mag;
	coord_t     step;
	coord_t     x_stepped;
	coord_t     left_stepped;
	coord_t     x_next;
	coord_t     scroll_next;

	// player in world space, x is the screen position
	assign world_right = x + scroll;
	assign world_left = world_right - `PF_SELF_W;
	assign top_px = y - `PF_SELF_H;
	assign box = '{right: world_right, bottom: y};

	// --------------------------------------------------
	// vertical, gravity and ground snap
	// --------------------------------------------------
	always_comb begin
		fall_probe = y + coord_t'(gravity) + 10'd1;
		in_air = corners_clear(fall_probe, fall_probe, world_left, world_right);
		if (in_air) begin
			// free fall, accelerate to terminal
			if (gravity >= `PF_V_TERMINAL)
				gravity_next = 4'(`PF_V_TERMINAL);
			else
				gravity_next = gravity + 4'd1;
		end else begin
			// ground ahead, take the biggest step that stays clear
			// ascending scan so the last hit is the largest
			gravity_next = 4'd0;
			for (int k = 1; k < `PF_V_TERMINAL; k++) begin
				if (corners_clear(y + coord_t'(k), y + coord_t'(k), world_left, world_right))
					gravity_next = 4'(k);
			end
		end
		y_next = y + coord_t'(gravity_next);
	end

	// --------------------------------------------------
	// horizontal, wall limit then window / scroll split
	// --------------------------------------------------
	always_comb begin
		step_mag = 3'd0;
		for (int s = 1; s <= `PF_MAX_VX; s++) begin
			// leading edge moved by s, checked at top and bottom
			if (move == MOVE_RIGHT) begin
				if (corners_clear(y, top_px, world_right + coord_t'(s), world_right + coord_t'(s)))
					step_mag = 3'(s);
			end else if (move == MOVE_LEFT) begin
				if (corners_clear(y, top_px, world_left + 10'd1 - coord_t'(s),
					world_left + 10'd1 - coord_t'(s)))
					step_mag = 3'(s);
			end
		end

		// two's complement step, left is negative
		if (move == MOVE_LEFT)
			step = 10'd0 - coord_t'(step_mag);
		else
			step = coord_t'(step_mag);

		x_stepped = x + step;
		left_stepped = x - `PF_SELF_W + step;

		if (x_stepped > `PF_MAX_X_VGA) begin
			// pushing past right window edge, world slides instead
			scroll_next = scroll + step;
			x_next = `PF_MAX_X_VGA;
		end else if (left_stepped <= `PF_MIN_X_VGA) begin
			// same on the left edge
			scroll_next = scroll + step;
			x_next = `PF_MIN_X_VGA + `PF_SELF_W - 1;
		end else begin
			scroll_next = scroll;
			x_next = x_stepped;
		end
	end

	// state moves only on accepted frames
	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			x <= `PF_START_X;
			y <= `PF_START_Y;
			scroll <= '0;
			gravity <= 4'd0;
		end else if (frame_go) begin
			x <= x_next;
			y <= y_next;
			scroll <= scroll_next;
			gravity <= gravity_next;
		end
	end

endmodule
